/* if_stage.f */
design/if_stage_pkg.sv
design/fetch_resp_if.sv
design/pc_select.sv
design/prefetch_ctrl.sv
design/align_buffer.sv
design/if_id_register.sv
design/if_stage_top.sv
verification/tb_if_stage.sv

/* Makefile */
# Verilator flow for the instruction fetch stage

VERILATOR ?= verilator
FILELIST  ?= if_stage.f
TB_TOP    ?= tb_if_stage
RTL_TOP   ?= if_stage_top
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --timescale $(TIMESCALE)
PASS_MSG  ?= Test completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# The run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_if_stage.sv */
////////////////////////////////////////
// Instruction fetch stage testbench
// Random bus and ID models, PC reference
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_if_stage
  import if_stage_pkg::*;
();

  logic        clk = 1'b0;
  logic        rst_n;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  addr_t       boot_addr_i;
  addr_t       jump_target_i;
  addr_t       branch_target_i;
  addr_t       mepc_i;
  addr_t       dpc_i;
  addr_t       dm_halt_addr_i;
  mtvec_addr_t mtvec_addr_i;
  irq_index_t  irq_index_i;
  logic        halt_if_i;
  logic        kill_if_i;
  logic        id_ready_i;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_err_i;
  logic        if_valid_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;
  logic        id_instr_valid_o;
  instr_t      id_instr_o;
  addr_t       id_pc_o;
  logic        id_bus_err_o;

  // Phase control written by the main flow
  logic        boot_en = 1'b0;
  logic        redir_en = 1'b0;
  logic        halt_en = 1'b0;
  logic        slow_id = 1'b0;
  logic        booted = 1'b0;

  logic [31:0] lfsr_state = 32'hd146_36b5;
  int          cyc = 0;
  int          err_cnt = 0;
  int          timeout_cnt = 0;
  int          deliv_cnt = 0;
  int          out_cnt = 0;

  // Bus model queue of granted addresses and their due cycles
  addr_t       rq_addr [$];
  int          rq_due [$];
  logic        err_map [addr_t];

  // Reference model state
  addr_t       exp_pc;
  logic        seen_set = 1'b0;
  logic [7:0]  mux_seen = '0;
  logic        boot_redir = 1'b0;
  logic        id_v_exp = 1'b0;
  logic        load_pend = 1'b0;
  addr_t       ld_pc;
  logic        hold_pend = 1'b0;
  instr_t      prev_instr;
  addr_t       prev_pc;
  logic        wait_pend = 1'b0;
  addr_t       wait_addr;

  if_stage_top u_if_stage_top (.*);

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois LFSR with taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Memory content depends on every address bit
  function automatic instr_t mix_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  // Redirect target from the currently driven sources
  function automatic addr_t expected_target();
    addr_t t;
    case (pc_mux_i)
      PC_BOOT:     t = boot_addr_i;
      PC_JUMP:     t = jump_target_i;
      PC_BRANCH:   t = branch_target_i;
      PC_MRET:     t = mepc_i;
      PC_DRET:     t = dpc_i;
      PC_TRAP_EXC: t = {mtvec_addr_i, 7'h00};
      PC_TRAP_IRQ: t = {mtvec_addr_i, irq_index_i, 2'b00};
      default:     t = dm_halt_addr_i;
    endcase
    return t & ~addr_t'(3);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      err_cnt++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic drive_redirect(input pc_mux_e mux);
    boot_redir      = (mux == PC_BOOT);
    pc_set_i        <= 1'b1;
    pc_mux_i        <= mux;
    boot_addr_i     <= rand_bits(32);
    jump_target_i   <= rand_bits(32);
    branch_target_i <= rand_bits(32);
    mepc_i          <= rand_bits(32);
    dpc_i           <= rand_bits(32);
    dm_halt_addr_i  <= rand_bits(32);
    mtvec_addr_i    <= mtvec_addr_t'(rand_bits(25));
    irq_index_i     <= irq_index_t'(rand_bits(5));
  endtask

  task automatic wait_deliveries(input int count, input int max_cycles, input string what);
    int target;
    int n;
    target = deliv_cnt + count;
    n = 0;
    while (deliv_cnt < target && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (deliv_cnt < target) begin
      timeout_cnt++;
      $display("Timeout: too few instructions reached ID during %s", what);
    end
  endtask

  task automatic wait_mux_coverage(input int max_cycles);
    int n;
    n = 0;
    while (mux_seen != 8'hff && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (mux_seen != 8'hff) begin
      timeout_cnt++;
      $display("Timeout: not every redirect source was used, seen %b", mux_seen);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus on the rising edge
  ////////////////////////////////////////

  always @(posedge clk) begin : drive_inputs
    logic [31:0] r;
    cyc = cyc + 1;
    r = rand_bits(1);
    instr_gnt_i <= r[0];
    // Oldest granted transfer answers once its delay ran out
    if (rq_addr.size() > 0 && rq_due[0] <= cyc) begin
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= mix_word(rq_addr[0]);
      instr_err_i    <= err_map[rq_addr[0]];
      void'(rq_addr.pop_front());
      void'(rq_due.pop_front());
    end else begin
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
      instr_err_i    <= 1'b0;
    end
    r = rand_bits(2);
    id_ready_i <= slow_id ? (r == 0) : (r != 0);
    if (halt_en) begin
      r = rand_bits(3);
      halt_if_i <= (r == 0);
      r = rand_bits(4);
      kill_if_i <= (r == 0);
    end
    // First redirect is always a boot
    if (boot_en && !booted) begin
      drive_redirect(PC_BOOT);
      booted = 1'b1;
    end else if (redir_en && rand_bits(5) == 0) begin
      r = rand_bits(3);
      drive_redirect(pc_mux_e'(r[2:0]));
    end else begin
      pc_set_i   <= 1'b0;
      boot_redir = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks at the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin : monitor_cycle
    logic        load_now;
    logic [31:0] r;
    if (!rst_n) begin
      check_value("reset instr_req_o", 32'd0, 32'(instr_req_o));
      check_value("reset if_valid_o", 32'd0, 32'(if_valid_o));
      check_value("reset id_instr_valid_o", 32'd0, 32'(id_instr_valid_o));
      check_value("reset if_busy_o", 32'd0, 32'(if_busy_o));
      check_value("reset csr_mtvec_init_o", 32'd0, 32'(csr_mtvec_init_o));
    end else begin
      // Results of the last edge
      check_value("id_instr_valid_o", 32'(id_v_exp), 32'(id_instr_valid_o));
      if (load_pend) begin
        check_value("delivered id_pc_o", ld_pc, id_pc_o);
        check_value("delivered id_instr_o", mix_word(ld_pc), id_instr_o);
        if (err_map.exists(ld_pc)) begin
          check_value("delivered id_bus_err_o", 32'(err_map[ld_pc]), 32'(id_bus_err_o));
        end else begin
          err_cnt++;
          $display("Delivered PC %h was never granted on the bus", ld_pc);
        end
      end
      if (hold_pend) begin
        check_value("stalled id_instr_o", prev_instr, id_instr_o);
        check_value("stalled id_pc_o", prev_pc, id_pc_o);
      end
      // State of this cycle
      if (!seen_set) begin
        check_value("instr_req_o before first redirect", 32'd0, 32'(instr_req_o));
      end
      check_value("csr_mtvec_init_o", 32'(boot_redir), 32'(csr_mtvec_init_o));
      if (halt_if_i || kill_if_i) begin
        check_value("if_valid_o under halt or kill", 32'd0, 32'(if_valid_o));
      end
      if (wait_pend) begin
        check_value("instr_req_o while waiting", 32'd1, 32'(instr_req_o));
        check_value("instr_addr_o while waiting", wait_addr, instr_addr_o);
      end
      check_value("if_busy_o", 32'(out_cnt != 0 || instr_req_o), 32'(if_busy_o));
      // Handover at the next edge belongs to the stream before any redirect
      load_now = if_valid_o && id_ready_i;
      if (load_now) begin
        ld_pc  = exp_pc;
        exp_pc = exp_pc + addr_t'(WORD_STRIDE);
        deliv_cnt++;
      end
      if (load_now) begin
        id_v_exp = 1'b1;
      end else if (id_ready_i) begin
        id_v_exp = 1'b0;
      end
      load_pend  = load_now;
      hold_pend  = !id_ready_i;
      prev_instr = id_instr_o;
      prev_pc    = id_pc_o;
      wait_pend  = instr_req_o && !instr_gnt_i;
      wait_addr  = instr_addr_o;
      // Bus model bookkeeping for the next edge
      if (instr_req_o && instr_gnt_i) begin
        if (!err_map.exists(instr_addr_o)) begin
          r = rand_bits(4);
          err_map[instr_addr_o] = (r == 0);
        end
        r = rand_bits(2);
        rq_addr.push_back(instr_addr_o);
        rq_due.push_back(cyc + 1 + int'(r[1:0]));
        out_cnt++;
      end
      if (instr_rvalid_i) begin
        out_cnt--;
      end
      if (out_cnt > MAX_OUTSTANDING) begin
        err_cnt++;
        $display("More than %0d bus transfers outstanding", MAX_OUTSTANDING);
      end
      if (pc_set_i) begin
        seen_set = 1'b1;
        exp_pc   = expected_target();
        mux_seen[int'(pc_mux_i)] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Main flow
  ////////////////////////////////////////

  initial begin : main_flow
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    dpc_i           = '0;
    dm_halt_addr_i  = '0;
    mtvec_addr_i    = '0;
    irq_index_i     = '0;
    halt_if_i       = 1'b0;
    kill_if_i       = 1'b0;
    id_ready_i      = 1'b0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Idle stretch where the stage must not fetch on its own
    repeat (12) @(posedge clk);
    boot_en <= 1'b1;
    wait_deliveries(40, 1000, "sequential fetch");
    redir_en <= 1'b1;
    halt_en  <= 1'b1;
    wait_mux_coverage(8000);
    wait_deliveries(300, 10000, "random redirects");
    // Mostly stalled ID fills the buffer
    slow_id <= 1'b1;
    wait_deliveries(60, 5000, "ID back-pressure");
    $display("Check errors: %0d, timeouts: %0d, instructions delivered: %0d",
             err_cnt, timeout_cnt, deliv_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/if_stage_top.sv */
////////////////////////////////////////
// Instruction fetch stage
// PC select, prefetch, buffer and IF/ID register
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module if_stage_top
  import if_stage_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Redirect request
  input  logic        pc_set_i,
  input  pc_mux_e     pc_mux_i,
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_i,
  input  addr_t       branch_target_i,
  input  addr_t       mepc_i,
  input  addr_t       dpc_i,
  input  addr_t       dm_halt_addr_i,
  input  mtvec_addr_t mtvec_addr_i,
  input  irq_index_t  irq_index_i,

  // Stage control
  input  logic        halt_if_i,
  input  logic        kill_if_i,
  input  logic        id_ready_i,

  // Instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_i,

  // Status and ID side
  output logic        if_valid_o,
  output logic        if_busy_o,
  output logic        csr_mtvec_init_o,
  output logic        id_instr_valid_o,
  output instr_t      id_instr_o,
  output addr_t       id_pc_o,
  output logic        id_bus_err_o
);

  addr_t  branch_addr;

  // Buffer head toward the IF/ID register
  logic   buf_valid;
  instr_t buf_instr;
  addr_t  buf_pc;
  logic   buf_err;
  logic   buf_pop;

  fetch_resp_if u_fetch_resp ();

  ////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////

  pc_select u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .dpc_i            (dpc_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_index_i      (irq_index_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_ctrl u_prefetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .resp           (u_fetch_resp.ctrl),
    .busy_o         (if_busy_o)
  );

  ////////////////////////////////////////
  // Buffering and handover
  ////////////////////////////////////////

  // Redirect empties the buffer
  align_buffer u_align_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (pc_set_i),
    .pop_i   (buf_pop),
    .resp    (u_fetch_resp.buffer),
    .valid_o (buf_valid),
    .instr_o (buf_instr),
    .pc_o    (buf_pc),
    .err_o   (buf_err)
  );

  if_id_register u_if_id_register (
    .clk              (clk),
    .rst_n            (rst_n),
    .buf_valid_i      (buf_valid),
    .instr_i          (buf_instr),
    .pc_i             (buf_pc),
    .err_i            (buf_err),
    .halt_if_i        (halt_if_i),
    .kill_if_i        (kill_if_i),
    .id_ready_i       (id_ready_i),
    .if_valid_o       (if_valid_o),
    .pop_o            (buf_pop),
    .id_instr_valid_o (id_instr_valid_o),
    .id_instr_o       (id_instr_o),
    .id_pc_o          (id_pc_o),
    .id_bus_err_o     (id_bus_err_o)
  );

endmodule

`default_nettype wire

/* design/if_id_register.sv */
////////////////////////////////////////
// IF/ID pipeline register
// Hands words to ID, holds while ID stalls
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module if_id_register
  import if_stage_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   buf_valid_i,
  input  instr_t instr_i,
  input  addr_t  pc_i,
  input  logic   err_i,
  input  logic   halt_if_i,
  input  logic   kill_if_i,
  input  logic   id_ready_i,
  output logic   if_valid_o,
  output logic   pop_o,
  output logic   id_instr_valid_o,
  output instr_t id_instr_o,
  output addr_t  id_pc_o,
  output logic   id_bus_err_o
);

  // Halt and kill both hide the buffered word
  assign if_valid_o = buf_valid_i && !halt_if_i && !kill_if_i;

  // Handover consumes the buffer head
  assign pop_o = if_valid_o && id_ready_i;

  ////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_instr_valid_o <= 1'b0;
    end else if (pop_o) begin
      id_instr_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      // ID took its word, nothing new to give
      id_instr_valid_o <= 1'b0;
    end
  end

  // Instruction fields, frozen while ID is stalled
  always_ff @(posedge clk) begin
    if (pop_o) begin
      id_instr_o   <= instr_i;
      id_pc_o      <= pc_i;
      id_bus_err_o <= err_i;
    end
  end

endmodule

`default_nettype wire

/* design/align_buffer.sv */
////////////////////////////////////////
// Alignment buffer
// Three-word instruction FIFO with flush
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module align_buffer
  import if_stage_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          flush_i,
  input  logic          pop_i,
  fetch_resp_if.buffer  resp,
  output logic          valid_o,
  output instr_t        instr_o,
  output addr_t         pc_o,
  output logic          err_o
);

  // Entry storage
  instr_t     instr_q [ALBUF_DEPTH];
  addr_t      pc_q    [ALBUF_DEPTH];
  logic       err_q   [ALBUF_DEPTH];

  albuf_cnt_t wr_ptr_q;
  albuf_cnt_t rd_ptr_q;
  albuf_cnt_t cnt_q;

  logic       push;
  logic       pop;

  // Wrap at the last entry
  function automatic albuf_cnt_t ptr_incr(albuf_cnt_t ptr);
    albuf_cnt_t nxt;
    if (ptr == albuf_cnt_t'(ALBUF_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + albuf_cnt_t'(1);
    end
    return nxt;
  endfunction

  // Flush wins over a write in the same cycle
  assign push = resp.resp_valid && !flush_i;
  assign pop  = pop_i && valid_o;

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) begin
        cnt_q <= cnt_q + albuf_cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - albuf_cnt_t'(1);
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (push) begin
      instr_q[wr_ptr_q] <= resp.resp_rdata;
      pc_q[wr_ptr_q]    <= resp.resp_addr;
      err_q[wr_ptr_q]   <= resp.resp_err;
    end
  end

  // Head entry
  assign valid_o = (cnt_q != '0);
  assign instr_o = instr_q[rd_ptr_q];
  assign pc_o    = pc_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];

  // Controller needs this to cap requests
  assign resp.occupancy = cnt_q;

endmodule

`default_nettype wire

/* design/prefetch_ctrl.sv */
////////////////////////////////////////
// Prefetch controller
// Issues word fetches, drops stale responses
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module prefetch_ctrl
  import if_stage_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pc_set_i,
  input  addr_t             branch_addr_i,
  output logic              instr_req_o,
  output addr_t             instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  instr_t            instr_rdata_i,
  input  logic              instr_err_i,
  fetch_resp_if.ctrl        resp,
  output logic              busy_o
);

  // Fetching runs once the first redirect arrives
  logic                     active_q;
  addr_t                    fetch_addr_q;
  // Ungranted request made stale, new target parked
  logic                     redir_pend_q;
  addr_t                    redir_addr_q;

  outstnd_cnt_t             outstnd_cnt_q;
  outstnd_cnt_t             outstnd_cnt_n;
  outstnd_cnt_t             discard_cnt_q;
  outstnd_cnt_t             discard_cnt_n;

  // Granted addresses in bus order
  addr_t                    tag_q [MAX_OUTSTANDING];
  logic                     tag_wr_ptr_q;
  logic                     tag_rd_ptr_q;

  logic [OUTSTND_CNT_WIDTH:0] inflight;
  logic                     has_room;
  logic                     gnt_fire;
  logic                     drop_resp;
  logic                     stale_gnt;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Transfers in flight plus words already buffered
  assign inflight = {1'b0, outstnd_cnt_q} + {1'b0, resp.occupancy};

  // Keep room for every answer that may come back
  assign has_room = (inflight < (OUTSTND_CNT_WIDTH + 1)'(ALBUF_DEPTH))
                 && (outstnd_cnt_q < outstnd_cnt_t'(MAX_OUTSTANDING));

  // Sum only grows on grants, so a waiting request stays up
  assign instr_req_o  = active_q && has_room;
  assign instr_addr_o = fetch_addr_q;
  assign gnt_fire     = instr_req_o && instr_gnt_i;

  // Grant of a request that a redirect already overtook
  assign stale_gnt = gnt_fire && redir_pend_q;

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  // Older stale answers come first on an in-order bus
  assign drop_resp = instr_rvalid_i && (discard_cnt_q != '0);

  assign resp.resp_valid = instr_rvalid_i && !drop_resp;
  assign resp.resp_rdata = instr_rdata_i;
  assign resp.resp_err   = instr_err_i;
  assign resp.resp_addr  = tag_q[tag_rd_ptr_q];

  always_comb begin
    outstnd_cnt_n = outstnd_cnt_q;
    if (gnt_fire && !instr_rvalid_i) begin
      outstnd_cnt_n = outstnd_cnt_q + outstnd_cnt_t'(1);
    end else if (!gnt_fire && instr_rvalid_i) begin
      outstnd_cnt_n = outstnd_cnt_q - outstnd_cnt_t'(1);
    end
  end

  always_comb begin
    discard_cnt_n = discard_cnt_q;
    if (pc_set_i) begin
      // Everything still in flight after this edge is stale
      discard_cnt_n = outstnd_cnt_n;
    end else if (stale_gnt && !drop_resp) begin
      discard_cnt_n = discard_cnt_q + outstnd_cnt_t'(1);
    end else if (drop_resp && !stale_gnt) begin
      discard_cnt_n = discard_cnt_q - outstnd_cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q      <= 1'b0;
      fetch_addr_q  <= ADDR_RESET_VAL;
      redir_pend_q  <= 1'b0;
      outstnd_cnt_q <= '0;
      discard_cnt_q <= '0;
      tag_wr_ptr_q  <= 1'b0;
      tag_rd_ptr_q  <= 1'b0;
    end else begin
      outstnd_cnt_q <= outstnd_cnt_n;
      discard_cnt_q <= discard_cnt_n;
      if (pc_set_i) begin
        active_q <= 1'b1;
        // A waiting request is never withdrawn
        if (instr_req_o && !instr_gnt_i) begin
          redir_pend_q <= 1'b1;
        end else begin
          redir_pend_q <= 1'b0;
          fetch_addr_q <= branch_addr_i;
        end
      end else if (gnt_fire) begin
        if (redir_pend_q) begin
          redir_pend_q <= 1'b0;
          fetch_addr_q <= redir_addr_q;
        end else begin
          fetch_addr_q <= fetch_addr_q + addr_t'(WORD_STRIDE);
        end
      end
      if (gnt_fire) begin
        tag_wr_ptr_q <= !tag_wr_ptr_q;
      end
      if (instr_rvalid_i) begin
        tag_rd_ptr_q <= !tag_rd_ptr_q;
      end
    end
  end

  // Address payload
  always_ff @(posedge clk) begin
    if (gnt_fire) begin
      tag_q[tag_wr_ptr_q] <= fetch_addr_q;
    end
    if (pc_set_i) begin
      redir_addr_q <= branch_addr_i;
    end
  end

  assign busy_o = (outstnd_cnt_q != '0) || instr_req_o;

endmodule

`default_nettype wire

/* design/pc_select.sv */
////////////////////////////////////////
// PC select
// Picks the redirect target from eight sources
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module pc_select
  import if_stage_pkg::*;
(
  input  pc_mux_e     pc_mux_i,
  input  logic        pc_set_i,
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_i,
  input  addr_t       branch_target_i,
  input  addr_t       mepc_i,
  input  addr_t       dpc_i,
  input  addr_t       dm_halt_addr_i,
  input  mtvec_addr_t mtvec_addr_i,
  input  irq_index_t  irq_index_i,
  output addr_t       branch_addr_o,
  output logic        csr_mtvec_init_o
);

  // Raw target before word alignment
  addr_t target;

  always_comb begin
    target = boot_addr_i;
    unique case (pc_mux_i)
      PC_BOOT:     target = boot_addr_i;
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      // Return from trap
      PC_MRET:     target = mepc_i;
      // Return from debug mode
      PC_DRET:     target = dpc_i;
      // Exceptions share the trap base
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored, one word per index
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_index_i, 2'b00};
      // Entry into debug mode
      PC_TRAP_DBD: target = dm_halt_addr_i;
      default:     target = boot_addr_i;
    endcase
  end

  // Only whole words are fetched
  assign branch_addr_o = {target[31:2], 2'b00};

  // Boot redirect lets the CSR file load mtvec
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

/* design/fetch_resp_if.sv */
////////////////////////////////////////
// Fetch response path
// Kept bus responses into the buffer
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface fetch_resp_if
  import if_stage_pkg::*;
();

  // Response accepted for the buffer
  logic       resp_valid;
  instr_t     resp_rdata;
  logic       resp_err;
  // Address the word was fetched from
  addr_t      resp_addr;

  // Words currently held in the buffer
  albuf_cnt_t occupancy;

  // Prefetch controller side
  modport ctrl (
    output resp_valid,
    output resp_rdata,
    output resp_err,
    output resp_addr,
    input  occupancy
  );

  // Alignment buffer side
  modport buffer (
    input  resp_valid,
    input  resp_rdata,
    input  resp_err,
    input  resp_addr,
    output occupancy
  );

endinterface

`default_nettype wire

/* design/if_stage_pkg.sv */
////////////////////////////////////////
// Instruction fetch stage package
// Widths, depths and redirect sources
////////////////////////////////////////

`default_nettype none

package if_stage_pkg;

  // Address and data words
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // Trap vector base, upper bits only
  typedef logic [24:0] mtvec_addr_t;

  // Vectored interrupt index
  typedef logic [4:0] irq_index_t;

  // Redirect sources for the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_DRET     = 3'd4,
    PC_TRAP_EXC = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_TRAP_DBD = 3'd7
  } pc_mux_e;

  ////////////////////////////////////////
  // Buffer and bus sizing
  ////////////////////////////////////////

  // Alignment buffer holds three words
  localparam int unsigned ALBUF_DEPTH     = 3;
  // Occupancy runs 0..ALBUF_DEPTH
  localparam int unsigned ALBUF_CNT_WIDTH = $clog2(ALBUF_DEPTH + 1);

  // Granted but unanswered transfers
  localparam int unsigned MAX_OUTSTANDING   = 2;
  localparam int unsigned OUTSTND_CNT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [ALBUF_CNT_WIDTH-1:0]   albuf_cnt_t;
  typedef logic [OUTSTND_CNT_WIDTH-1:0] outstnd_cnt_t;

  // Byte step between sequential words
  localparam int unsigned WORD_STRIDE = 4;

  // Fetch address after reset, unused until first redirect
  localparam addr_t ADDR_RESET_VAL = '0;

endpackage

`default_nettype wire
